//--- Bender.yml
package:
  name: io_subsys

export_include_dirs:
  - logic

sources:
  - files:
      - logic/io_pkg.sv
      - logic/io_decode.sv
      - logic/ms_timer.sv
      - logic/watchdog.sv
      - logic/stackmon.sv
      - logic/io_rsp_mux.sv
      - logic/io_subsys.sv
  - target: test
    files:
      - tb/tb_io_subsys.sv

//--- list.f
+incdir+logic
logic/io_pkg.sv
logic/io_decode.sv
logic/ms_timer.sv
logic/watchdog.sv
logic/stackmon.sv
logic/io_rsp_mux.sv
logic/io_subsys.sv
tb/tb_io_subsys.sv

//--- logic/io_decode.sv
`timescale 1ns/1ps
`include "io_defs.svh"

// address decode for the extended i/o window
// one strobe per device, no registers in here
module io_decode import io_pkg::*; (
  input  bus_req_t req,   // cpu request
  output dev_sel_t sel    // device strobes
);

  logic       io_stb;   // strobe inside the window
  logic [5:0] offs;     // word offset within the window

  // ----------------------------------------------------------------------
  // window hit
  // ----------------------------------------------------------------------

  // 256 bytes at 0xFFFF00, i.e. top 16 word-address bits all ones
  assign io_stb = req.stb && (req.addr[23:8] == `IO_WINDOW_TAG);
  assign offs   = req.addr[7:2];

  // ----------------------------------------------------------------------
  // per-device strobes
  // ----------------------------------------------------------------------

  always_comb begin
    sel = '0;   // no device unless the window hits
    if (io_stb) begin
      // single word devices, full offset compare
      sel.tmr = (offs == `IO_OFFS_TMR);   // -64
      sel.wd  = (offs == `IO_OFFS_WD);    // -112
      // four words, bits 3..2 pick the register
      sel.stm = (offs[5:2] == `IO_OFFS_STM);
    end
  end

  // unmapped offsets leave all bits low
  // the response mux then gives ack low and zero data

endmodule

//--- logic/io_defs.svh
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// ----------------------------------------------------------------------
// clocking
// ----------------------------------------------------------------------

`define IO_CLOCK_FREQ 50_000_000                   // system clock, Hz
`define IO_CYCLES_PER_MS (`IO_CLOCK_FREQ / 1000)   // default ms prescale

// ----------------------------------------------------------------------
// i/o window, 256 bytes at 0xFFFF00
// ----------------------------------------------------------------------

`define IO_WINDOW_TAG 16'hFFFF   // word address bits 23..8

// word offsets in the window, address bits 7..2
`define IO_OFFS_TMR 6'b110000    // -64, ms timer
`define IO_OFFS_WD  6'b100100    // -112, watchdog

// stack monitor spans four words, compared on bits 7..4
`define IO_OFFS_STM 4'b1010      // -96 .. -84

`endif

//--- logic/io_pkg.sv
package io_pkg;

  // ----------------------------------------------------------------------
  // cpu side bus
  // ----------------------------------------------------------------------

  // one request, valid while stb is high
  typedef struct packed {
    logic        stb;     // transfer strobe
    logic        we;      // write enable
    logic [23:2] addr;    // word address
    logic [31:0] wdata;   // write data
  } bus_req_t;

  // device response, ack in the strobe cycle
  typedef struct packed {
    logic [31:0] rdata;   // read data, valid with ack
    logic        ack;     // transfer done
  } bus_rsp_t;

  // ----------------------------------------------------------------------
  // decode and register maps
  // ----------------------------------------------------------------------

  // one-hot device strobes out of the decoder
  typedef struct packed {
    logic tmr;   // ms timer
    logic wd;    // watchdog
    logic stm;   // stack monitor
  } dev_sel_t;

  // stack monitor registers, addr bits 3..2
  typedef enum logic [1:0] {
    stm_limit  = 2'd0,   // stack limit
    stm_hot    = 2'd1,   // hot zone threshold
    stm_min_sp = 2'd2,   // lowest sp seen
    stm_status = 2'd3    // trigger bits
  } stm_reg_t;

endpackage

//--- logic/io_rsp_mux.sv
`timescale 1ns/1ps

// response merge for the i/o devices
// fixed priority with the timer first
module io_rsp_mux import io_pkg::*; (
  input  dev_sel_t sel,       // strobes from decode
  input  bus_rsp_t tmr_rsp,   // ms timer
  input  bus_rsp_t wd_rsp,    // watchdog
  input  bus_rsp_t stm_rsp,   // stack monitor
  output bus_rsp_t rsp        // back to the cpu
);

  // ----------------------------------------------------------------------
  // data and ack select
  // ----------------------------------------------------------------------

  // decode is one-hot for mapped offsets
  // priority only matters if that ever breaks
  always_comb begin
    if (sel.tmr) begin
      rsp = tmr_rsp;
    end else if (sel.wd) begin
      rsp = wd_rsp;
    end else if (sel.stm) begin
      rsp = stm_rsp;
    end else begin
      // nothing addressed
      rsp.rdata = 32'h0;   // zero data
      rsp.ack   = 1'b0;    // cpu sees no device
    end
  end

  // no wait states added here
  // ack comes straight from the device in the strobe cycle

endmodule

//--- logic/io_subsys.sv
`timescale 1ns/1ps
`include "io_defs.svh"

// extended i/o block
// decode, three devices, response merge
module io_subsys import io_pkg::*; #(
  parameter int cycles_per_ms = `IO_CYCLES_PER_MS
) (
  input  logic        clk,
  input  logic        rst_n,
  input  bus_req_t    req,            // cpu request
  input  logic [23:0] sp,             // cpu stack pointer
  output bus_rsp_t    rsp,            // merged response
  output logic        wd_trig,        // watchdog timeout
  output logic        stm_trig_lim,   // stack limit hit
  output logic        stm_trig_hot    // stack hot zone hit
);

  dev_sel_t sel;       // device strobes
  bus_rsp_t tmr_rsp;   // per device responses
  bus_rsp_t wd_rsp;
  bus_rsp_t stm_rsp;
  logic     ms_tick;   // timer to watchdog

  // ----------------------------------------------------------------------
  // input side
  // ----------------------------------------------------------------------

  io_decode decode_0 (.req(req), .sel(sel));

  // ----------------------------------------------------------------------
  // devices
  // ----------------------------------------------------------------------

  // one word at -64
  ms_timer #(.cycles_per_ms(cycles_per_ms)) tmr_0 (
    .clk(clk), .rst_n(rst_n), .req(req), .sel(sel.tmr),
    .rsp(tmr_rsp), .ms_tick(ms_tick)
  );

  // one word at -112
  watchdog watchdog_0 (
    .clk(clk), .rst_n(rst_n), .req(req), .sel(sel.wd),
    .ms_tick(ms_tick), .rsp(wd_rsp), .trig(wd_trig)
  );

  // four words at -96
  stackmon stackmon_0 (
    .clk(clk), .rst_n(rst_n), .req(req), .sel(sel.stm), .sp(sp),
    .rsp(stm_rsp), .trig_lim(stm_trig_lim), .trig_hot(stm_trig_hot)
  );

  // ----------------------------------------------------------------------
  // output side
  // ----------------------------------------------------------------------

  io_rsp_mux rsp_mux_0 (
    .sel(sel), .tmr_rsp(tmr_rsp), .wd_rsp(wd_rsp), .stm_rsp(stm_rsp),
    .rsp(rsp)
  );

endmodule

//--- logic/ms_timer.sv
`timescale 1ns/1ps
`include "io_defs.svh"

// millisecond timer
// prescaler for the tick, 32-bit count of ms since reset
module ms_timer import io_pkg::*; #(
  parameter int cycles_per_ms = `IO_CYCLES_PER_MS
) (
  input  logic     clk,
  input  logic     rst_n,
  input  bus_req_t req,       // shared request
  input  logic     sel,       // device strobe
  output bus_rsp_t rsp,       // device response
  output logic     ms_tick    // one cycle per ms
);

  localparam int presc_w = (cycles_per_ms > 1) ? $clog2(cycles_per_ms) : 1;
  localparam logic [presc_w-1:0] presc_last = presc_w'(cycles_per_ms - 1);

  logic [presc_w-1:0] presc;      // cycles within the current ms
  logic [31:0]        ms_count;   // ms since reset

  // ----------------------------------------------------------------------
  // prescaler and tick
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      presc   <= '0;
      ms_tick <= 1'b0;
    end else if (presc == presc_last) begin
      presc   <= '0;   // wrap, tick in the next cycle
      ms_tick <= 1'b1;
    end else begin
      presc   <= presc + 1'b1;
      ms_tick <= 1'b0;
    end
  end

  // count follows the tick by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n)       ms_count <= '0;
    else if (ms_tick) ms_count <= ms_count + 32'd1;
  end

  // read only, writes get acked and dropped
  assign rsp.ack   = sel;
  assign rsp.rdata = req.we ? 32'h0 : ms_count;

endmodule

//--- logic/stackmon.sv
`timescale 1ns/1ps

// stack monitor
// limit and hot zone checks on the cpu sp, plus low water mark
module stackmon import io_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  bus_req_t    req,        // shared request
  input  logic        sel,        // device strobe
  input  logic [23:0] sp,         // cpu stack pointer
  output bus_rsp_t    rsp,        // device response
  output logic        trig_lim,   // sp below limit, sticky
  output logic        trig_hot    // sp in hot zone, sticky
);

  stm_reg_t    reg_idx;    // register addressed
  logic        wr;         // write strobe
  logic [23:0] wdata;      // threshold width
  logic [23:0] limit;      // hard stack limit, 0 = off
  logic [23:0] hot;        // hot zone bound, 0 = off
  logic [23:0] min_sp;     // lowest sp so far

  assign reg_idx = stm_reg_t'(req.addr[3:2]);
  assign wr      = sel && req.we;
  assign wdata   = req.wdata[23:0];

  // ----------------------------------------------------------------------
  // threshold registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      limit <= '0;
      hot   <= '0;
    end else if (wr) begin
      if (reg_idx == stm_limit) limit <= wdata;
      if (reg_idx == stm_hot)   hot   <= wdata;
    end
  end

  // low water mark, a write restarts it from the top
  always_ff @(posedge clk) begin
    if (!rst_n)                           min_sp <= 24'hFFFFFF;
    else if (wr && reg_idx == stm_min_sp) min_sp <= 24'hFFFFFF;
    else if (sp < min_sp)                 min_sp <= sp;
  end

  // ----------------------------------------------------------------------
  // triggers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trig_lim <= 1'b0;
      trig_hot <= 1'b0;
    end else if (wr && reg_idx == stm_status) begin
      trig_lim <= 1'b0;   // status write acks both
      trig_hot <= 1'b0;
    end else begin
      if (limit != '0 && sp < limit) trig_lim <= 1'b1;
      if (hot != '0 && sp < hot)     trig_hot <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // read back
  // ----------------------------------------------------------------------

  always_comb begin
    case (reg_idx)
      stm_limit:  rsp.rdata = {8'h0, limit};
      stm_hot:    rsp.rdata = {8'h0, hot};
      stm_min_sp: rsp.rdata = {8'h0, min_sp};
      default:    rsp.rdata = {30'h0, trig_hot, trig_lim};   // status
    endcase
  end

  assign rsp.ack = sel;   // single cycle, all four words

endmodule

//--- logic/watchdog.sv
`timescale 1ns/1ps

// watchdog, counts down in ms
// a write reloads it, hitting zero raises trig
module watchdog import io_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  bus_req_t req,       // shared request
  input  logic     sel,       // device strobe
  input  logic     ms_tick,   // from ms timer
  output bus_rsp_t rsp,       // device response
  output logic     trig       // timeout, sticky
);

  logic        wr;       // write to the watchdog
  logic [15:0] reload;   // last timeout written
  logic [15:0] remain;   // ms left

  assign wr = sel && req.we;

  // ----------------------------------------------------------------------
  // countdown
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reload <= '0;
      remain <= '0;
      trig   <= 1'b0;
    end else if (wr) begin
      // reload and rearm, zero timeout turns it off
      reload <= req.wdata[15:0];
      remain <= req.wdata[15:0];
      trig   <= 1'b0;
    end else if (ms_tick && (remain != 16'd0)) begin
      remain <= remain - 16'd1;
      // last ms gone
      if (remain == 16'd1) begin
        trig <= 1'b1;   // held until the next write
      end
    end
  end

  // ----------------------------------------------------------------------
  // bus side
  // ----------------------------------------------------------------------

  // Remaining count in the upper half so software can poll progress.
  assign rsp.ack   = sel;
  assign rsp.rdata = {remain, reload};

endmodule

//--- tb/tb_io_subsys.sv
`timescale 1ns/1ps
`include "io_defs.svh"

// directed testbench for the extended i/o block
module tb_io_subsys import io_pkg::*; ();

  localparam int cyc_per_ms = 10;     // short ms for simulation
  localparam int max_cycles = 2000;   // several times the whole test run

  // byte addresses of the device registers
  localparam logic [23:0] tmr_addr = {`IO_WINDOW_TAG, `IO_OFFS_TMR, 2'b00};
  localparam logic [23:0] wd_addr  = {`IO_WINDOW_TAG, `IO_OFFS_WD, 2'b00};
  localparam logic [23:0] lim_addr = {`IO_WINDOW_TAG, `IO_OFFS_STM, 4'h0};
  localparam logic [23:0] hot_addr = {`IO_WINDOW_TAG, `IO_OFFS_STM, 4'h4};
  localparam logic [23:0] min_addr = {`IO_WINDOW_TAG, `IO_OFFS_STM, 4'h8};
  localparam logic [23:0] sta_addr = {`IO_WINDOW_TAG, `IO_OFFS_STM, 4'hC};

  logic        clk;
  logic        rst_n;
  bus_req_t    req;
  logic [23:0] sp;
  bus_rsp_t    rsp;
  logic        wd_trig;
  logic        stm_trig_lim;
  logic        stm_trig_hot;

  int unsigned cyc = 0;       // cycle index since reset release
  int unsigned run_cyc = 0;   // every cycle for the timeout

  io_subsys #(.cycles_per_ms(cyc_per_ms)) dut (
    .clk(clk), .rst_n(rst_n), .req(req), .sp(sp), .rsp(rsp),
    .wd_trig(wd_trig), .stm_trig_lim(stm_trig_lim), .stm_trig_hot(stm_trig_hot)
  );

  // ----------------------------------------------------------------------
  // clock, cycle count, timeout
  // ----------------------------------------------------------------------

  initial clk = 1'b0;
  always #5 clk = ~clk;   // 10 ns period

  // ms tick is high in cycles 10, 20, ... of this count
  always @(posedge clk) begin
    if (!rst_n) cyc <= 0;
    else        cyc <= cyc + 1;
  end

  always @(posedge clk) begin
    run_cyc <= run_cyc + 1;
    if (run_cyc == max_cycles) begin
      $display("Timeout: tests did not finish within %0d clock cycles", max_cycles);
      $display("STATUS: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // one transfer between two falling edges
  task automatic bus_access(input logic we, input logic [23:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic ack);
    req.stb   = 1'b1;
    req.we    = we;
    req.addr  = addr[23:2];   // word address
    req.wdata = wdata;
    #1;
    rdata = rsp.rdata;   // sampled mid cycle
    ack   = rsp.ack;
    @(negedge clk);
    req = '0;   // bus idle
  endtask

  task automatic bus_write(input logic [23:0] addr, input logic [31:0] wdata,
                           output logic ack);
    logic [31:0] unused;
    bus_access(1'b1, addr, wdata, unused, ack);
  endtask

  task automatic bus_read(input logic [23:0] addr, output logic [31:0] rdata,
                          output logic ack);
    bus_access(1'b0, addr, 32'h0, rdata, ack);
  endtask

  // mapped write that must be acked
  task automatic write_ok(input string name, input logic [23:0] addr,
                          input logic [31:0] wdata);
    logic ack;
    bus_write(addr, wdata, ack);
    check_value({name, " write ack"}, ack, 1);
  endtask

  task automatic read_expect(input string name, input logic [23:0] addr,
                             input logic [31:0] exp);
    logic [31:0] rd;
    logic        ack;
    bus_read(addr, rd, ack);
    check_value({name, " read ack"}, ack, 1);
    check_value(name, rd, exp);
  endtask

  task automatic wait_until(input int unsigned target);
    if (cyc > target) begin
      $display("Test sequence fell behind, cycle %0d is past %0d", cyc, target);
      $display("STATUS: FAIL");
      $fatal(1, "wait target missed");
    end else begin
      while (cyc != target) @(negedge clk);
    end
  endtask

  // position within the ms period
  task automatic align_phase(input int unsigned phase);
    while (cyc % cyc_per_ms != phase) @(negedge clk);
  endtask

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------

  task automatic reset_state();
    check_value("wd_trig", wd_trig, 0);
    check_value("stm_trig_lim", stm_trig_lim, 0);
    check_value("stm_trig_hot", stm_trig_hot, 0);
    check_value("rsp.ack idle", rsp.ack, 0);
    read_expect("watchdog", wd_addr, 32'h0);
    read_expect("stm status", sta_addr, 32'h0);
    read_expect("stm min_sp", min_addr, 32'h00FFFFFF);
  endtask

  task automatic timer_counts();
    int unsigned k;
    int unsigned t0;
    logic [31:0] v0;
    logic [31:0] v1;
    logic        ack;
    k  = 1 + $urandom % 8;
    t0 = cyc;
    bus_read(tmr_addr, v0, ack);
    check_value("timer read ack", ack, 1);
    check_value("ms_count", v0, (t0 - 1) / cyc_per_ms);   // ticks before t0
    wait_until(t0 + k * cyc_per_ms);
    bus_read(tmr_addr, v1, ack);
    check_value("ms_count delta", v1 - v0, k);
    // no tick between phase 2 and 4
    align_phase(2);
    t0 = cyc;
    read_expect("ms_count", tmr_addr, (t0 - 1) / cyc_per_ms);
    write_ok("timer", tmr_addr, $urandom);
    read_expect("ms_count after write", tmr_addr, (t0 - 1) / cyc_per_ms);
  endtask

  task automatic watchdog_timeout();
    int unsigned n;
    int unsigned w;
    n = 2 + $urandom % 4;
    align_phase(1);   // one cycle past a tick
    w = cyc;
    write_ok("watchdog", wd_addr, n);
    // n-th tick in cycle w+10n-1
    // trig visible one cycle later
    wait_until(w + n * cyc_per_ms - 1);
    check_value("wd_trig before timeout", wd_trig, 0);
    wait_until(w + n * cyc_per_ms);
    check_value("wd_trig at timeout", wd_trig, 1);
    read_expect("watchdog", wd_addr, n);   // remain 0 and reload n
    repeat (20) @(negedge clk);
    check_value("wd_trig sticky", wd_trig, 1);
    write_ok("watchdog", wd_addr, n);
    check_value("wd_trig after reload", wd_trig, 0);
    write_ok("watchdog", wd_addr, 32'h0);   // off
    repeat (100) begin
      @(negedge clk);
      check_value("wd_trig disabled", wd_trig, 0);
    end
    read_expect("watchdog off", wd_addr, 32'h0);
  endtask

  task automatic stack_checks();
    logic [23:0] limit;
    logic [23:0] hot;
    logic [23:0] sp_mid;
    logic [23:0] sp_low;
    limit  = 24'h100000 + ($urandom % 24'h100000);
    hot    = limit + 24'h100 + ($urandom % 24'h10000);   // always above limit
    sp_mid = limit + ((hot - limit) >> 1);
    sp_low = limit - 24'd1 - ($urandom % 24'h100);
    write_ok("stm limit", lim_addr, limit);
    write_ok("stm hot", hot_addr, hot);
    read_expect("stm limit", lim_addr, limit);
    read_expect("stm hot", hot_addr, hot);
    sp = sp_mid;   // hot zone only
    #1;
    check_value("stm_trig_hot before edge", stm_trig_hot, 0);
    @(negedge clk);
    check_value("stm_trig_hot", stm_trig_hot, 1);
    check_value("stm_trig_lim", stm_trig_lim, 0);
    sp = sp_low;   // past the limit
    @(negedge clk);
    check_value("stm_trig_lim", stm_trig_lim, 1);
    sp = 24'hFFFFFF;   // stack unwound
    repeat (5) @(negedge clk);
    check_value("stm_trig_lim sticky", stm_trig_lim, 1);
    check_value("stm_trig_hot sticky", stm_trig_hot, 1);
    read_expect("stm status", sta_addr, 32'h3);
    read_expect("stm min_sp", min_addr, sp_low);
    write_ok("stm status", sta_addr, 32'h0);
    check_value("stm_trig_lim cleared", stm_trig_lim, 0);
    check_value("stm_trig_hot cleared", stm_trig_hot, 0);
    read_expect("stm status", sta_addr, 32'h0);
    write_ok("stm min_sp", min_addr, 32'h0);
    read_expect("stm min_sp restart", min_addr, 32'h00FFFFFF);
  endtask

  task automatic decode_map();
    logic [31:0] rd;
    logic        ack;
    // tag mismatch with the timer's low bits
    bus_read(24'hFEFFC0, rd, ack);
    check_value("outside read ack", ack, 0);
    check_value("outside read rdata", rd, 32'h0);
    bus_write(24'h00FF90, 32'h7, ack);   // watchdog alias outside
    check_value("outside write ack", ack, 0);
    // unmapped offsets inside the window
    bus_read({`IO_WINDOW_TAG, 8'h00}, rd, ack);
    check_value("unmapped 0x00 ack", ack, 0);
    check_value("unmapped 0x00 rdata", rd, 32'h0);
    bus_read({`IO_WINDOW_TAG, 8'hB0}, rd, ack);
    check_value("unmapped 0xB0 ack", ack, 0);
    check_value("unmapped 0xB0 rdata", rd, 32'h0);
    read_expect("watchdog untouched", wd_addr, 32'h0);
    // watchdog write leaves the stack monitor alone
    write_ok("stm limit", lim_addr, 32'h0ABCDE);
    write_ok("stm hot", hot_addr, 32'h0BCDEF);
    write_ok("watchdog", wd_addr, 32'h1234);
    read_expect("watchdog", wd_addr, 32'h12341234);
    read_expect("stm limit kept", lim_addr, 32'h0ABCDE);
    read_expect("stm hot kept", hot_addr, 32'h0BCDEF);
    // and the reverse
    write_ok("watchdog", wd_addr, 32'h0);
    write_ok("stm limit", lim_addr, 32'h012345);
    read_expect("watchdog kept", wd_addr, 32'h0);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    void'($urandom(32'h607306fb));
    rst_n = 1'b0;
    req   = '0;
    sp    = 24'hFFFFFF;   // top of memory so no trigger
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    reset_state();
    timer_counts();
    watchdog_timeout();
    stack_checks();
    decode_map();
    repeat (2) @(negedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule
